// ==== Bender.yml ====
package:
  name: micro_cpu

sources:
  - cpu_pkg.sv
  - control_rom.sv
  - microsequencer.sv
  - register_file.sv
  - alu.sv
  - datapath.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - tb_cpu_top.sv

// ==== alu.sv ====
// 32-bit ALU; carry on SUB is set when no borrow occurs, and logical ops clear C and V.
`timescale 1ns/10ps

module alu (
  input  logic [3:0]                 op,
  input  logic [cpu_pkg::data_w-1:0] a,
  input  logic [cpu_pkg::data_w-1:0] b,
  output logic [cpu_pkg::data_w-1:0] y,
  output logic                       z,
  output logic                       n,
  output logic                       c,
  output logic                       v
);
  import cpu_pkg::*;

  logic [data_w:0] sum;
  logic [data_w:0] diff;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;  // a - b as a + ~b + 1.

  always_comb begin
    c = 1'b0;
    v = 1'b0;
    case (op)
      alu_pass_a: y = a;
      alu_pass_b: y = b;
      alu_add: begin
        y = sum[data_w-1:0];
        c = sum[data_w];
        v = (a[data_w-1] == b[data_w-1]) && (y[data_w-1] != a[data_w-1]);
      end
      alu_sub: begin
        y = diff[data_w-1:0];
        c = diff[data_w];
        // operands of opposite sign can overflow on subtraction.
        v = (a[data_w-1] != b[data_w-1]) && (y[data_w-1] != a[data_w-1]);
      end
      alu_and: y = a & b;
      alu_orr: y = a | b;
      default: y = '0;
    endcase
  end

  assign z = (y == '0);
  assign n = y[data_w-1];

endmodule

// ==== control_rom.sv ====
// combinational microprogram store; any microstate not listed below returns to fetch.
`timescale 1ns/10ps

module control_rom (
  input  logic [cpu_pkg::state_w-1:0] state,
  output logic [cpu_pkg::ctrl_w-1:0]  ctrl
);
  import cpu_pkg::*;

  always_comb begin
    ctrl = '0;                                      // the default word jumps to st_fetch.
    ctrl[f_next_type +: nt_w]    = nt_jump;
    ctrl[f_const_val +: const_w] = 16'(st_fetch);
    case (state)
      st_fetch: begin                               // mar takes the pc.
        ctrl[f_next_type +: nt_w]   = nt_incr;
        ctrl[f_sel_a +: sel_w]      = a_pc;
        ctrl[f_alu_op +: alu_op_w]  = alu_pass_a;
        ctrl[f_ld_mar]              = 1'b1;
      end
      st_fetch_wait: begin
        // read the instruction word and stay here until the memory completes.
        ctrl[f_next_type +: nt_w]    = nt_cond;
        ctrl[f_cond_sel +: cc_w]     = cc_moc;
        ctrl[f_inv]                  = 1'b1;
        ctrl[f_const_val +: const_w] = 16'(st_fetch_wait);
        ctrl[f_mem_mov]              = 1'b1;
        ctrl[f_ld_mdr]               = 1'b1;
        ctrl[f_sel_mdr]              = 1'b1;
      end
      st_decode: begin                              // ir from mdr while the pc steps by four.
        ctrl[f_next_type +: nt_w]    = nt_incr;
        ctrl[f_ld_ir]                = 1'b1;
        ctrl[f_sel_a +: sel_w]       = a_pc;
        ctrl[f_sel_b +: sel_w]       = b_const;
        ctrl[f_const_val +: const_w] = 16'd4;
        ctrl[f_alu_op +: alu_op_w]   = alu_add;
        ctrl[f_ld_rf]                = 1'b1;
        ctrl[f_sel_dest]             = 1'b1;
      end
      st_dispatch: ctrl[f_next_type +: nt_w] = nt_dispatch;
      op_add, op_sub, op_and, op_orr: begin         // rd = rn op rm, flags updated.
        ctrl[f_sel_a +: sel_w] = a_rn;
        ctrl[f_sel_b +: sel_w] = b_rm;
        ctrl[f_ld_rf]          = 1'b1;
        ctrl[f_ld_flags]       = 1'b1;
        case (state)
          op_add:  ctrl[f_alu_op +: alu_op_w] = alu_add;
          op_sub:  ctrl[f_alu_op +: alu_op_w] = alu_sub;
          op_and:  ctrl[f_alu_op +: alu_op_w] = alu_and;
          default: ctrl[f_alu_op +: alu_op_w] = alu_orr;
        endcase
      end
      op_movi, st_branch: begin                     // the immediate goes to rd, or to the pc.
        ctrl[f_sel_b +: sel_w]     = b_imm;
        ctrl[f_alu_op +: alu_op_w] = alu_pass_b;
        ctrl[f_ld_rf]              = 1'b1;
        ctrl[f_sel_dest]           = (state == st_branch);
      end
      op_ldr, op_str: begin                         // address is rn plus the immediate.
        ctrl[f_next_type +: nt_w]  = nt_incr;
        ctrl[f_sel_b +: sel_w]     = b_imm;
        ctrl[f_alu_op +: alu_op_w] = alu_add;
        ctrl[f_ld_mar]             = 1'b1;
        ctrl[f_ld_mdr]             = (state == op_str); // store data comes from rd.
      end
      op_ldr + 8'd1, op_str + 8'd1: begin
        ctrl[f_next_type +: nt_w]    = nt_cond;
        ctrl[f_cond_sel +: cc_w]     = cc_moc;
        ctrl[f_inv]                  = 1'b1;
        ctrl[f_const_val +: const_w] = 16'(state);
        ctrl[f_mem_mov]              = 1'b1;
        ctrl[f_mem_rw]               = (state == op_str + 8'd1);
        ctrl[f_ld_mdr]               = (state == op_ldr + 8'd1);
        ctrl[f_sel_mdr]              = 1'b1;
      end
      op_ldr + 8'd2: begin                          // rd takes the loaded word.
        ctrl[f_sel_b +: sel_w]     = b_mdr;
        ctrl[f_alu_op +: alu_op_w] = alu_pass_b;
        ctrl[f_ld_rf]              = 1'b1;
      end
      op_bz, op_bnz: begin
        ctrl[f_next_type +: nt_w]    = nt_cond;
        ctrl[f_cond_sel +: cc_w]     = cc_z;
        ctrl[f_inv]                  = (state == op_bnz);
        ctrl[f_const_val +: const_w] = 16'(st_branch);
      end
      op_halt: begin
        ctrl[f_next_type +: nt_w] = nt_hold;
        ctrl[f_halt]              = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== cpu_pkg.sv ====
// shared widths, control-word layout and encodings; only word accesses exist and there are no interrupts.
package cpu_pkg;

  localparam int data_w  = 32;
  localparam int state_w = 8;

  // widths of the multi-bit control fields.
  localparam int nt_w     = 3;
  localparam int cc_w     = 3;
  localparam int const_w  = 16;
  localparam int sel_w    = 2;
  localparam int alu_op_w = 4;

  // control word layout, packed from bit 0 upward.
  localparam int f_alu_op    = 0;
  localparam int f_sel_mdr   = f_alu_op + alu_op_w;
  localparam int f_sel_dest  = f_sel_mdr + 1;
  localparam int f_sel_b     = f_sel_dest + 1;
  localparam int f_sel_a     = f_sel_b + sel_w;
  localparam int f_halt      = f_sel_a + sel_w;
  localparam int f_mem_rw    = f_halt + 1;
  localparam int f_mem_mov   = f_mem_rw + 1;
  localparam int f_ld_flags  = f_mem_mov + 1;
  localparam int f_ld_rf     = f_ld_flags + 1;
  localparam int f_ld_mdr    = f_ld_rf + 1;
  localparam int f_ld_mar    = f_ld_mdr + 1;
  localparam int f_ld_ir     = f_ld_mar + 1;
  localparam int f_const_val = f_ld_ir + 1;
  localparam int f_cond_sel  = f_const_val + const_w;
  localparam int f_inv       = f_cond_sel + cc_w;
  localparam int f_next_type = f_inv + 1;
  localparam int ctrl_w      = f_next_type + nt_w;

  localparam logic [nt_w-1:0] nt_incr     = 3'd0;
  localparam logic [nt_w-1:0] nt_jump     = 3'd1;
  localparam logic [nt_w-1:0] nt_dispatch = 3'd2;
  localparam logic [nt_w-1:0] nt_cond     = 3'd3;
  localparam logic [nt_w-1:0] nt_hold     = 3'd4;

  localparam logic [cc_w-1:0] cc_always = 3'd0;
  localparam logic [cc_w-1:0] cc_z      = 3'd1;
  localparam logic [cc_w-1:0] cc_n      = 3'd2;
  localparam logic [cc_w-1:0] cc_c      = 3'd3;
  localparam logic [cc_w-1:0] cc_v      = 3'd4;
  localparam logic [cc_w-1:0] cc_moc    = 3'd5;

  // each opcode is also the first microstate of its routine.
  localparam logic [7:0] op_add  = 8'h10;
  localparam logic [7:0] op_sub  = 8'h11;
  localparam logic [7:0] op_and  = 8'h12;
  localparam logic [7:0] op_orr  = 8'h13;
  localparam logic [7:0] op_movi = 8'h14;
  localparam logic [7:0] op_ldr  = 8'h18;
  localparam logic [7:0] op_str  = 8'h1c;
  localparam logic [7:0] op_bz   = 8'h20;
  localparam logic [7:0] op_bnz  = 8'h24;
  localparam logic [7:0] op_halt = 8'h28;

  localparam logic [state_w-1:0] st_fetch      = 8'd0;
  localparam logic [state_w-1:0] st_fetch_wait = 8'd1;
  localparam logic [state_w-1:0] st_decode     = 8'd2;
  localparam logic [state_w-1:0] st_dispatch   = 8'd3;
  localparam logic [state_w-1:0] st_branch     = 8'h22; // taken branch, shared by bz and bnz.

  localparam logic [alu_op_w-1:0] alu_pass_a = 4'd0;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd1;
  localparam logic [alu_op_w-1:0] alu_add    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd4;
  localparam logic [alu_op_w-1:0] alu_orr    = 4'd5;

  localparam logic [sel_w-1:0] a_rn    = 2'd0;
  localparam logic [sel_w-1:0] a_pc    = 2'd1;
  localparam logic [sel_w-1:0] b_rm    = 2'd0;
  localparam logic [sel_w-1:0] b_imm   = 2'd1;
  localparam logic [sel_w-1:0] b_const = 2'd2;
  localparam logic [sel_w-1:0] b_mdr   = 2'd3;

  // instruction format; a branch target sits in the imm field.
  localparam int ir_op_lsb  = 24;
  localparam int ir_rd_lsb  = 20;
  localparam int ir_rn_lsb  = 16;
  localparam int ir_rm_lsb  = 12;
  localparam int ir_imm_lsb = 0;
  localparam int imm_w      = 16;

endpackage

// ==== cpu_props.sv ====
// protocol checks for the memory port and HALT; they assume one mem_moc per request.
`timescale 1ns/10ps

module cpu_props (
  input logic                       clk,
  input logic                       rst,
  input logic [cpu_pkg::data_w-1:0] mem_addr,
  input logic [cpu_pkg::data_w-1:0] mem_wdata,
  input logic                       mem_rw,
  input logic                       mem_mov,
  input logic                       mem_moc,
  input logic                       halted
);

  int unsigned fails = 0;

  // the first microstate after reset is st_fetch, which issues no request.
  mov_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !mem_mov)
    else begin
      fails++;
      $error("mem_mov high in the first cycle after reset");
    end

  req_held: assert property (@(posedge clk) disable iff (rst)
      (mem_mov && !mem_moc) |=> $stable(mem_addr) && $stable(mem_rw))
    else begin
      fails++;
      $error("address or direction changed before mem_moc");
    end

  wdata_held: assert property (@(posedge clk) disable iff (rst)
      (mem_mov && mem_rw && !mem_moc) |=> $stable(mem_wdata))
    else begin
      fails++;
      $error("write data changed before mem_moc");
    end

  no_req_halted: assert property (@(posedge clk) disable iff (rst) halted |-> !mem_mov)
    else begin
      fails++;
      $error("memory request while halted");
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else begin
      fails++;
      $error("halted fell without a reset");
    end

endmodule

// ==== cpu_top.sv ====
// microprogrammed CPU top; memory must answer each mem_mov with a single-cycle mem_moc.
`timescale 1ns/10ps

module cpu_top (
  input  logic                       clk,
  input  logic                       rst,
  output logic [cpu_pkg::data_w-1:0] mem_addr,
  output logic [cpu_pkg::data_w-1:0] mem_wdata,
  output logic                       mem_rw,
  output logic                       mem_mov,
  input  logic [cpu_pkg::data_w-1:0] mem_rdata,
  input  logic                       mem_moc,
  output logic                       halted
);
  import cpu_pkg::*;

  logic [state_w-1:0] state;
  logic [ctrl_w-1:0]  ctrl;
  logic [7:0]         ir_opcode;
  logic               z;
  logic               n;
  logic               c;
  logic               v;

  // these come straight from the control word of the current microstate.
  assign mem_mov = ctrl[f_mem_mov];
  assign mem_rw  = ctrl[f_mem_rw];   // 1 is a write.
  assign halted  = ctrl[f_halt];

  control_rom i_rom (
    .state (state),
    .ctrl  (ctrl)
  );

  microsequencer i_seq (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .ir_opcode (ir_opcode),
    .z         (z),
    .n         (n),
    .c         (c),
    .v         (v),
    .mem_moc   (mem_moc),
    .state     (state)
  );

  datapath i_dp (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .mem_moc   (mem_moc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ir_opcode (ir_opcode),
    .z         (z),
    .n         (n),
    .c         (c),
    .v         (v)
  );

endmodule

// ==== datapath.sv ====
// MAR and MDR drive the memory ports directly; IR, MAR and MDR are not cleared by reset.
`timescale 1ns/10ps

module datapath (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [cpu_pkg::ctrl_w-1:0] ctrl,
  input  logic [cpu_pkg::data_w-1:0] mem_rdata,
  input  logic                       mem_moc,
  output logic [cpu_pkg::data_w-1:0] mem_addr,
  output logic [cpu_pkg::data_w-1:0] mem_wdata,
  output logic [7:0]                 ir_opcode,
  output logic                       z,
  output logic                       n,
  output logic                       c,
  output logic                       v
);
  import cpu_pkg::*;

  logic [data_w-1:0] ir;
  logic [data_w-1:0] mar;
  logic [data_w-1:0] mdr;
  logic [data_w-1:0] a_bus;
  logic [data_w-1:0] b_bus;
  logic [data_w-1:0] alu_y;
  logic [data_w-1:0] ra_data;
  logic [data_w-1:0] rb_data;
  logic [data_w-1:0] pc;
  logic [3:0]        rd;
  logic [3:0]        rn;
  logic [3:0]        rm;
  logic [3:0]        rb_addr;
  logic [3:0]        w_addr;
  logic [imm_w-1:0]  imm;
  logic [sel_w-1:0]  sel_b;
  logic              mdr_en;
  logic              alu_z;
  logic              alu_n;
  logic              alu_c;
  logic              alu_v;

  assign ir_opcode = ir[ir_op_lsb +: 8];
  assign rd        = ir[ir_rd_lsb +: 4];
  assign rn        = ir[ir_rn_lsb +: 4];
  assign rm        = ir[ir_rm_lsb +: 4];
  assign imm       = ir[ir_imm_lsb +: imm_w];
  assign sel_b     = ctrl[f_sel_b +: sel_w];

  // port b reads rm for register ops and rd otherwise, which feeds the store data.
  assign rb_addr = (sel_b == b_rm) ? rm : rd;
  assign w_addr  = ctrl[f_sel_dest] ? 4'd15 : rd;

  assign a_bus = (ctrl[f_sel_a +: sel_w] == a_pc) ? pc : ra_data;

  always_comb begin
    case (sel_b)
      b_rm:    b_bus = rb_data;
      b_imm:   b_bus = {{(data_w - imm_w){1'b0}}, imm};   // zero-extended.
      b_const: b_bus = {{(data_w - const_w){1'b0}}, ctrl[f_const_val +: const_w]};
      default: b_bus = mdr;
    endcase
  end

  // in memory mode the MDR only takes the read data in the completion cycle.
  assign mdr_en = ctrl[f_ld_mdr] && (!ctrl[f_sel_mdr] || mem_moc);

  always_ff @(posedge clk) begin
    if (ctrl[f_ld_ir]) ir <= mdr;
    if (ctrl[f_ld_mar]) mar <= alu_y;
    if (mdr_en) mdr <= ctrl[f_sel_mdr] ? mem_rdata : rb_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      {z, n, c, v} <= 4'b0000;
    end else if (ctrl[f_ld_flags]) begin
      {z, n, c, v} <= {alu_z, alu_n, alu_c, alu_v};
    end
  end

  assign mem_addr  = mar;
  assign mem_wdata = mdr;

  register_file i_rf (
    .clk     (clk),
    .rst     (rst),
    .ra_addr (rn),
    .rb_addr (rb_addr),
    .w_addr  (w_addr),
    .w_en    (ctrl[f_ld_rf]),
    .w_data  (alu_y),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .pc      (pc)
  );

  alu i_alu (
    .op (ctrl[f_alu_op +: alu_op_w]),
    .a  (a_bus),
    .b  (b_bus),
    .y  (alu_y),
    .z  (alu_z),
    .n  (alu_n),
    .c  (alu_c),
    .v  (alu_v)
  );

endmodule

// ==== filelist.f ====
cpu_pkg.sv
control_rom.sv
microsequencer.sv
register_file.sv
alu.sv
datapath.sv
cpu_top.sv
cpu_props.sv
tb_cpu_top.sv

// ==== microsequencer.sv ====
// one microstate per clock; the condition mux only matters for nt_cond words.
`timescale 1ns/10ps

module microsequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [cpu_pkg::ctrl_w-1:0]  ctrl,
  input  logic [7:0]                  ir_opcode,
  input  logic                        z,
  input  logic                        n,
  input  logic                        c,
  input  logic                        v,
  input  logic                        mem_moc,
  output logic [cpu_pkg::state_w-1:0] state
);
  import cpu_pkg::*;

  logic [nt_w-1:0]    next_type;
  logic [cc_w-1:0]    cond_sel;
  logic [state_w-1:0] target;
  logic [state_w-1:0] state_inc;
  logic [state_w-1:0] state_nxt;
  logic               cond_raw;
  logic               cond;

  assign next_type = ctrl[f_next_type +: nt_w];
  assign cond_sel  = ctrl[f_cond_sel +: cc_w];
  assign target    = ctrl[f_const_val +: state_w]; // jump targets live in the low byte.
  assign state_inc = state + 8'd1;

  always_comb begin
    case (cond_sel)
      cc_always: cond_raw = 1'b1;
      cc_z:      cond_raw = z;
      cc_n:      cond_raw = n;
      cc_c:      cond_raw = c;
      cc_v:      cond_raw = v;
      cc_moc:    cond_raw = mem_moc;
      default:   cond_raw = 1'b0;
    endcase
  end

  assign cond = cond_raw ^ ctrl[f_inv];

  always_comb begin
    case (next_type)
      nt_incr:     state_nxt = state_inc;
      nt_jump:     state_nxt = target;
      nt_dispatch: state_nxt = ir_opcode;             // opcodes are routine addresses.
      nt_cond:     state_nxt = cond ? target : state_inc;
      nt_hold:     state_nxt = state;
      default:     state_nxt = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== register_file.sv ====
// sixteen registers, R15 is the program counter; a read in the write cycle sees the old value.
`timescale 1ns/10ps

module register_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [3:0]                 ra_addr,
  input  logic [3:0]                 rb_addr,
  input  logic [3:0]                 w_addr,
  input  logic                       w_en,
  input  logic [cpu_pkg::data_w-1:0] w_data,
  output logic [cpu_pkg::data_w-1:0] ra_data,
  output logic [cpu_pkg::data_w-1:0] rb_data,
  output logic [cpu_pkg::data_w-1:0] pc
);
  import cpu_pkg::*;

  logic [data_w-1:0] regs [16];

  // every register restarts at zero, so the first fetch is from address 0.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr];
  assign pc      = regs[15];

endmodule

// ==== tb_cpu_top.sv ====
// memory is 256 words addressed by bits 9:2; the program must not write R15 and must end in HALT.
`timescale 1ns/10ps

module tb_cpu_top;
  import cpu_pkg::*;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] mem_rdata = '0;
  logic        mem_moc = 1'b0;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_rw;
  logic        mem_mov;
  logic        halted;

  logic [31:0] mem [256];
  logic [31:0] model_r [16];         // register contents as the ISA defines them.
  logic        model_z;
  int unsigned pc_word = 0;
  int unsigned n_exec = 0;
  int unsigned limit_cycles = 0;
  int unsigned errors = 0;
  int unsigned req_count = 0;
  int unsigned wr_idx = 0;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];

  always #10 clk = ~clk;

  cpu_top i_dut (.*);

  bind cpu_top cpu_props i_props (.*);

  function automatic logic [31:0] encode(input logic [7:0] op, input logic [3:0] rd,
                                         input logic [3:0] rn, input logic [15:0] low);
    return {op, rd, rn, low};
  endfunction

  function automatic logic [31:0] isa_result(input logic [7:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      default: return a | b;
    endcase
  endfunction

  task automatic place(input logic [31:0] word, input bit run);
    mem[pc_word] = word;
    pc_word++;
    if (run) n_exec++;
  endtask

  task automatic emit_movi(input logic [3:0] rd, input logic [15:0] imm, input bit run = 1'b1);
    place(encode(op_movi, rd, 4'd0, imm), run);
    if (run) model_r[rd] = {16'h0000, imm};
  endtask

  task automatic emit_alu(input logic [7:0] op, input logic [3:0] rd, input logic [3:0] rn,
                          input logic [3:0] rm);
    logic [31:0] res;
    place(encode(op, rd, rn, {rm, 12'h000}), 1'b1);
    res = isa_result(op, model_r[rn], model_r[rm]);
    model_r[rd] = res;
    model_z = (res == 32'h0);
  endtask

  task automatic emit_ldr(input logic [3:0] rd, input logic [15:0] addr);
    place(encode(op_ldr, rd, 4'd0, addr), 1'b1);   // r0 stays zero, so imm is the address.
    model_r[rd] = mem[addr[9:2]];
  endtask

  task automatic emit_str(input logic [3:0] rd, input logic [15:0] addr, input string name,
                          input bit run = 1'b1);
    place(encode(op_str, rd, 4'd0, addr), run);
    if (run) begin
      exp_addr.push_back({16'h0000, addr});
      exp_data.push_back(model_r[rd]);
      exp_name.push_back(name);
    end
  endtask

  // a taken branch skips one marker store, and the landing marker is always stored.
  task automatic branch_case(input logic [7:0] op, input logic [15:0] fall,
                             input logic [15:0] land, input logic [15:0] addr, input string name);
    bit          taken;
    logic [15:0] target;
    taken = (op == op_bz) ? model_z : !model_z;
    target = 16'((pc_word + 3) * 4);
    place(encode(op, 4'd0, 4'd0, target), 1'b1);
    emit_movi(4'd12, fall, !taken);
    emit_str(4'd12, addr, {name, " fall-through"}, !taken);
    emit_movi(4'd12, land);
    emit_str(4'd12, addr + 16'd4, {name, " landing"});
  endtask

  task automatic build_program();
    for (int i = 0; i < 256; i++) mem[i] = 32'h5eed_0000 + i;
    foreach (model_r[i]) model_r[i] = '0;
    model_z = 1'b0;
    mem[192] = 32'hffff_fff0;                        // preloaded words at 0x300.
    mem[193] = 32'h0000_0025;
    mem[194] = 32'h8bad_f00d;
    emit_str(4'd13, 16'h0200, "r13 after reset");    // r13 is set before the second reset.
    emit_movi(4'd13, 16'h5a5a);
    emit_movi(4'd10, 16'hbeef);
    emit_str(4'd10, 16'h0204, "movi zero-extend");
    emit_ldr(4'd1, 16'h0300);
    emit_ldr(4'd2, 16'h0304);
    emit_alu(op_add, 4'd3, 4'd1, 4'd2);
    emit_str(4'd3, 16'h0210, "add wraparound");
    emit_movi(4'd4, 16'd5);
    emit_movi(4'd5, 16'd9);
    emit_alu(op_sub, 4'd6, 4'd4, 4'd5);
    emit_str(4'd6, 16'h0214, "sub borrow");
    emit_alu(op_and, 4'd7, 4'd1, 4'd2);
    emit_str(4'd7, 16'h0218, "and");
    emit_alu(op_orr, 4'd8, 4'd1, 4'd2);
    emit_str(4'd8, 16'h021c, "orr");
    emit_ldr(4'd9, 16'h0308);
    emit_str(4'd9, 16'h0220, "ldr then str");
    emit_movi(4'd1, 16'd7);
    emit_movi(4'd2, 16'd7);
    emit_alu(op_sub, 4'd3, 4'd1, 4'd2);              // zero difference.
    branch_case(op_bz, 16'hf001, 16'h1a01, 16'h0240, "bz on zero");
    branch_case(op_bnz, 16'hf002, 16'h1a02, 16'h0248, "bnz on zero");
    emit_movi(4'd2, 16'd3);
    emit_alu(op_sub, 4'd3, 4'd1, 4'd2);
    branch_case(op_bz, 16'hf003, 16'h1a03, 16'h0250, "bz on nonzero");
    branch_case(op_bnz, 16'hf004, 16'h1a04, 16'h0258, "bnz on nonzero");
    emit_str(4'd13, 16'h0260, "r13 set");
    place(encode(op_halt, 4'd0, 4'd0, 16'h0000), 1'b1);
    limit_cycles = 64 * 2 * n_exec;                  // a partial run before the reset, then a full one.
  endtask

  task automatic check_store();
    assert (wr_idx < exp_addr.size()) else begin
      errors++;
      $display("unexpected store of %h to address %h", mem_wdata, mem_addr);
    end
    if (wr_idx < exp_addr.size()) begin
      assert (mem_addr == exp_addr[wr_idx] && mem_wdata == exp_data[wr_idx]) else begin
        errors++;
        $display("mismatch %s: expected %h at %h, actual %h at %h", exp_name[wr_idx],
                 exp_data[wr_idx], exp_addr[wr_idx], mem_wdata, mem_addr);
      end
    end
    wr_idx++;
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // memory answers each request once, after a random delay of 1 to 4 cycles.
  initial begin : memory_model
    logic [7:0]  idx;
    bit          busy;
    bit          first_req;
    int unsigned delay;
    void'($urandom(50));
    busy = 1'b0;
    first_req = 1'b1;
    forever begin
      @(posedge clk);
      if (rst) begin
        mem_moc <= 1'b0;
        busy = 1'b0;
        first_req = 1'b1;
        wr_idx = 0;
      end else if (mem_moc) begin
        mem_moc <= 1'b0;
      end else if (busy) begin
        if (delay > 1) begin
          delay--;
        end else begin
          idx = mem_addr[9:2];
          if (mem_rw) begin
            check_store();
            mem[idx] = mem_wdata;
          end
          mem_rdata <= mem[idx];
          mem_moc <= 1'b1;
          busy = 1'b0;
        end
      end else if (mem_mov) begin
        if (first_req) begin
          assert (mem_addr == 32'h0 && !mem_rw) else begin
            errors++;
            $display("mismatch first request: expected read of %h, actual rw %b at %h",
                     32'h0, mem_rw, mem_addr);
          end
          first_req = 1'b0;
        end
        req_count++;
        busy = 1'b1;
        delay = 1 + ($urandom % 4);
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: CPU did not reach HALT within %0d cycles", limit_cycles);
    $display("checks failed: %0d in testbench, %0d in bound assertions", errors,
             i_dut.i_props.fails);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main_sequence
    int unsigned halt_reqs;
    build_program();
    apply_reset();
    wait (wr_idx >= 2);                              // reset again in the middle of the program.
    @(posedge clk);
    apply_reset();
    wait (halted === 1'b1);
    @(posedge clk);
    halt_reqs = req_count;
    repeat (20) @(posedge clk);
    assert (halted === 1'b1) else begin
      errors++;
      $display("halted dropped after HALT");
    end
    assert (req_count == halt_reqs) else begin
      errors++;
      $display("memory request issued after HALT");
    end
    assert (wr_idx == exp_addr.size()) else begin
      errors++;
      $display("only %0d of %0d expected stores were seen", wr_idx, exp_addr.size());
    end
    $display("checks failed: %0d in testbench, %0d in bound assertions", errors,
             i_dut.i_props.fails);
    if (errors == 0 && i_dut.i_props.fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
